//--- ExecCore.f
hdl/Types.sv
hdl/ALU.sv
hdl/StageEX.sv
hdl/InstDecoder.sv
hdl/RegisterFile.sv
hdl/ApbInstPort.sv
hdl/ExecCore.sv
dv/ExecCore_properties.sv
dv/ExecCore_tb.sv

//--- dv/ExecCore_properties.sv
`timescale 1ns/1ns

module ExecCore_properties (
    input logic i_clock,
    input logic i_rst,
    input logic i_psel,
    input logic i_penable,
    input logic i_pready,
    input logic i_issue,
    input logic i_busy);    // ID/EX valid

    // ----------------------------------------------------------------------
    // APB protocol
    // ----------------------------------------------------------------------

    readyInAccess: assert property (@(posedge i_clock) disable iff (i_rst)
        i_pready |-> (i_psel && i_penable))
        else $error("PREADY high outside an APB access phase");

    // ----------------------------------------------------------------------
    // Pipeline
    // ----------------------------------------------------------------------

    issueOneCycle: assert property (@(posedge i_clock) disable iff (i_rst)
        i_issue |=> !i_issue)
        else $error("Issue strobe held longer than one cycle");

    issueNotBusy: assert property (@(posedge i_clock) disable iff (i_rst)
        i_issue |-> !i_busy)
        else $error("Issue strobe while the ID/EX slot is occupied");

endmodule

bind ApbInstPort ExecCore_properties props (
    .i_clock   (i_clock),
    .i_rst     (i_rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pready  (o_pready),
    .i_issue   (o_issue),
    .i_busy    (i_busy));

//--- dv/ExecCore_tb.sv
`timescale 1ns/1ns

module ExecCore_tb;

    localparam int TIMEOUT_CYCLES = 20000;   // ~400 transfers of at most 6 cycles
    localparam int ALU_INSTS      = 150;
    localparam Types::InstAddr RESET_PC = 32'h0000_0100;

    logic          i_clock   = 1'b0;
    logic          i_rst     = 1'b1;
    logic          i_psel    = 1'b0;
    logic          i_penable = 1'b0;
    logic          i_pwrite  = 1'b0;
    Types::ApbAddr i_paddr   = '0;
    Types::Data    i_pwdata  = '0;
    Types::Data    o_prdata;
    logic          o_pready;
    logic          o_pslverr;

    // Reference state
    Types::Data     model [32];
    Types::InstAddr modelPc;

    logic [31:0] seed     = 32'h102c;
    int          cycles   = 0;
    int          checks   = 0;
    int          errors   = 0;
    string       testName = "none";

    ExecCore #(
        .RESET_PC   (RESET_PC),
        .DATA_WIDTH (32))
    ExecCore_i (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr));

    always #5 i_clock = ~i_clock;                    // 10 ns period

    always @(posedge i_clock) begin
        cycles <= cycles + 1;
    end

    // ----------------------------------------------------------------------
    // Random numbers and instruction model
    // ----------------------------------------------------------------------

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Low LCG bits have short periods so keep the upper halves
    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcgNext();
        lo = lcgNext();
        return {hi[31:16], lo[31:16]};
    endfunction

    // RV32I result for OP, OP-IMM, LUI and AUIPC
    function automatic Types::Data refResult(input Types::Inst inst, input Types::InstAddr pc);
        Types::Data a;
        Types::Data b;
        logic [2:0] f3;
        logic       isOp;
        isOp = inst[6:0] == 7'h33;
        f3   = inst[14:12];
        a    = model[inst[19:15]];
        b    = isOp ? model[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        if (inst[6:0] == 7'h37) begin
            return {inst[31:12], 12'h000};           // LUI
        end
        if (inst[6:0] == 7'h17) begin
            return pc + {inst[31:12], 12'h000};      // AUIPC
        end
        case (f3)
            3'b000:  return (isOp && inst[30]) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return inst[30] ? Types::Data'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Random OP or OP-IMM word with x0 as target about one time in eight
    function automatic Types::Inst makeAluInst();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        r  = rand32();
        f3 = r[14:12];
        f7 = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;   // SUB, SRA
        rd = (r[3:1] == 3'b000) ? 5'd0 : r[11:7];
        if (!r[0]) begin
            return {f7, r[24:20], r[19:15], f3, rd, 7'h33};
        end
        if (f3 == 3'b001 || f3 == 3'b101) begin
            return {f7, r[24:20], r[19:15], f3, rd, 7'h13};             // Shift immediates
        end
        return {r[31:20], r[19:15], f3, rd, 7'h13};
    endfunction

    // ----------------------------------------------------------------------
    // APB master and checks
    // ----------------------------------------------------------------------

    task automatic apbAccess(input logic write, input Types::ApbAddr addr,
                             input Types::Data wdata, output Types::Data rdata,
                             output logic err);
        i_psel    = 1'b1;                            // Setup phase
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge i_clock);
        #1;
        i_penable = 1'b1;
        do begin
            @(posedge i_clock);
            #1;
        end while (!o_pready);                       // Wait states while busy
        rdata = o_prdata;
        err   = o_pslverr;
        @(posedge i_clock);                          // Access ends on this edge
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic checkValue(input string what, input Types::Data expected,
                              input Types::Data actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s %s expected %08h actual %08h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic issueInst(input Types::Inst inst);
        Types::Data result;
        Types::Data rdata;
        logic       err;
        result = refResult(inst, modelPc);
        apbAccess(1'b1, Types::INST_ADDR, inst, rdata, err);
        checkValue($sformatf("issue %08h pslverr", inst), 32'd0, Types::Data'(err));
        if (inst[11:7] != 5'd0) begin
            model[inst[11:7]] = result;
        end
        modelPc = modelPc + 32'd4;
    endtask

    task automatic readAllRegs();
        Types::Data rdata;
        logic       err;
        for (int n = 0; n < 32; n++) begin
            apbAccess(1'b0, Types::REG_BASE + Types::ApbAddr'(n * 4), '0, rdata, err);
            checkValue($sformatf("x%0d", n), model[n], rdata);
            checkValue($sformatf("x%0d pslverr", n), 32'd0, Types::Data'(err));
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        Types::Data rdata;
        Types::Data value;
        Types::Inst inst;
        logic       err;
        for (int n = 0; n < 32; n++) begin
            model[n] = '0;
        end
        modelPc = RESET_PC;
        repeat (16) @(posedge i_clock);
        #1;
        i_rst = 1'b0;

        testName = "reset";                          // All registers clear
        readAllRegs();
        apbAccess(1'b0, Types::PC_ADDR, '0, rdata, err);
        checkValue("pc", modelPc, rdata);

        testName = "alu";
        repeat (ALU_INSTS) issueInst(makeAluInst());
        readAllRegs();
        apbAccess(1'b0, Types::PC_ADDR, '0, rdata, err);
        checkValue("pc", modelPc, rdata);

        // PC load then upper immediates
        testName = "upper";
        value = rand32() & 32'hffff_fffc;
        apbAccess(1'b1, Types::PC_ADDR, value, rdata, err);
        modelPc = value;
        apbAccess(1'b0, Types::PC_ADDR, '0, rdata, err);
        checkValue("pc", modelPc, rdata);
        repeat (12) begin
            value = rand32();
            issueInst({value[31:7], value[2] ? 7'h17 : 7'h37});    // AUIPC or LUI
        end
        readAllRegs();

        // Error responses leave state alone
        testName = "error";
        repeat (20) begin
            inst = rand32();
            while (inst[6:0] inside {7'h13, 7'h33, 7'h17, 7'h37}) begin
                inst = rand32();
            end
            apbAccess(1'b1, Types::INST_ADDR, inst, rdata, err);
            checkValue($sformatf("illegal %08h pslverr", inst), 32'd1, Types::Data'(err));
            value = rand32();
            apbAccess(1'b1, Types::REG_BASE + {1'b0, value[4:0], 2'b00}, value, rdata, err);
            checkValue("register write pslverr", 32'd1, Types::Data'(err));
        end
        apbAccess(1'b0, 8'h08, '0, rdata, err);      // Unmapped
        checkValue("unmapped read pslverr", 32'd1, Types::Data'(err));
        apbAccess(1'b0, Types::PC_ADDR, '0, rdata, err);
        checkValue("pc", modelPc, rdata);
        issueInst({20'h00001, 5'd7, 7'h17});         // AUIPC x7 shows the PC
        readAllRegs();

        // Readback straight behind each issue
        testName = "back-to-back";
        repeat (24) begin
            inst = makeAluInst();
            issueInst(inst);
            apbAccess(1'b0, Types::REG_BASE + {1'b0, inst[11:7], 2'b00}, '0, rdata, err);
            checkValue($sformatf("x%0d", inst[11:7]), model[inst[11:7]], rdata);
        end

        $display("Summary %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (cycles == TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, an APB transfer never completed", cycles);
        $display("Summary %0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- hdl/ALU.sv
`timescale 1ns/1ns

module ALU #(
    parameter int DATA_WIDTH = 32)
(
    input  Types::AluOp i_op,          // Operation from decode
    input  Types::Data  i_operandA,
    input  Types::Data  i_operandB,
    output Types::Data  o_result);

    // Shift amount from the low bits of B
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

    logic [SHAMT_WIDTH-1:0] shamt;
    logic                   lessSigned;
    logic                   lessUnsigned;

    assign shamt        = i_operandB[SHAMT_WIDTH-1:0];
    assign lessSigned   = $signed(i_operandA) < $signed(i_operandB);
    assign lessUnsigned = i_operandA < i_operandB;

    // ----------------------------------------------------------------------
    // Operation select
    // ----------------------------------------------------------------------

    always_comb begin
        case (i_op)
            Types::ALU_ADD:  o_result = i_operandA + i_operandB;
            Types::ALU_SUB:  o_result = i_operandA - i_operandB;
            Types::ALU_SLL:  o_result = i_operandA << shamt;
            Types::ALU_SLT:  o_result = {{(DATA_WIDTH-1){1'b0}}, lessSigned};
            Types::ALU_SLTU: o_result = {{(DATA_WIDTH-1){1'b0}}, lessUnsigned};
            Types::ALU_XOR:  o_result = i_operandA ^ i_operandB;
            Types::ALU_SRL:  o_result = i_operandA >> shamt;   // Zero fill
            Types::ALU_SRA: begin
                // Sign fill from bit 31
                o_result = $signed(i_operandA) >>> shamt;
            end
            Types::ALU_OR:   o_result = i_operandA | i_operandB;
            Types::ALU_AND:  o_result = i_operandA & i_operandB;
            default:         o_result = '0;                    // Unused codes
        endcase
    end

endmodule

//--- hdl/ApbInstPort.sv
`timescale 1ns/1ns

module ApbInstPort #(
    parameter Types::InstAddr RESET_PC = 32'h0)
(
    input  logic           i_clock,
    input  logic           i_rst,
    input  logic           i_psel,
    input  logic           i_penable,
    input  logic           i_pwrite,
    input  Types::ApbAddr  i_paddr,
    input  Types::Data     i_pwdata,
    output Types::Data     o_prdata,
    output logic           o_pready,
    output logic           o_pslverr,
    input  logic           i_legal,      // Decode of the written word
    input  logic           i_busy,       // ID/EX valid
    input  Types::Data     i_regData,    // Readback port of the register file
    output logic           o_issue,
    output Types::Inst     o_inst,
    output Types::InstAddr o_pc,
    output Types::RegIndex o_regIdx);

    typedef enum logic [1:0] {
        IDLE,                            // No transfer
        ACCESS,                          // First access cycle
        WAIT                             // Held off by the pipeline
    } ApbState;

    ApbState state;
    logic    stall;
    logic    complete;
    logic    isInst;
    logic    isPc;
    logic    isReg;
    logic    badAccess;

    // Pipeline busy or issuing right now
    assign stall    = i_busy || o_issue;
    assign complete = (state == ACCESS || state == WAIT) && !stall;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------

    assign isInst = i_paddr == Types::INST_ADDR;
    assign isPc   = i_paddr == Types::PC_ADDR;
    assign isReg  = ((i_paddr & Types::REG_BASE) == Types::REG_BASE) && i_paddr[1:0] == 2'b00;

    // Register window is read only and INST is write only
    assign badAccess = i_pwrite ? !(isPc || (isInst && i_legal)) : !(isPc || isReg);

    assign o_inst   = i_pwdata;          // Stable through the access phase
    assign o_regIdx = Types::RegIndex'((i_paddr - Types::REG_BASE) >> 2);

    // ----------------------------------------------------------------------
    // Transfer FSM and PC
    // ----------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state     <= IDLE;
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
            o_issue   <= 1'b0;
            o_pc      <= RESET_PC;
        end else begin
            o_pready  <= 1'b0;           // Ready and strobe last one cycle
            o_pslverr <= 1'b0;
            o_issue   <= 1'b0;
            if (o_issue) begin
                o_pc <= o_pc + 32'd4;    // Next sequential address
            end
            case (state)
                IDLE: begin
                    if (i_psel && !i_penable) begin
                        state <= ACCESS;     // Setup phase seen
                    end
                end
                ACCESS, WAIT: begin
                    if (!complete) begin
                        state <= WAIT;
                    end else begin
                        state     <= IDLE;
                        o_pready  <= 1'b1;
                        o_pslverr <= badAccess;
                        o_issue   <= i_pwrite && isInst && i_legal;
                        if (i_pwrite && isPc) begin
                            o_pc <= i_pwdata;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Readback data
    always_ff @(posedge i_clock) begin
        if (complete && !i_pwrite) begin
            o_prdata <= isReg ? i_regData : o_pc;
        end
    end

endmodule

//--- hdl/ExecCore.sv
`timescale 1ns/1ns

module ExecCore #(
    parameter Types::InstAddr RESET_PC   = 32'h0,
    parameter int             DATA_WIDTH = 32)
(
    input  logic          i_clock,
    input  logic          i_rst,
    input  logic          i_psel,
    input  logic          i_penable,
    input  logic          i_pwrite,
    input  Types::ApbAddr i_paddr,
    input  Types::Data    i_pwdata,
    output Types::Data    o_prdata,
    output logic          o_pready,
    output logic          o_pslverr);

    // Issue side
    logic           issue;
    logic           legal;
    Types::Inst     inst;
    Types::InstAddr pc;
    Types::RegIndex regIdx;
    Types::Data     regData;

    // ID stage
    Types::ExCtrl   decCtrl;
    Types::ExCtrl   idCtrl;
    Types::Data     idImm;
    Types::RegIndex rs1;
    Types::RegIndex rs2;
    Types::Data     rs1Data;
    Types::Data     rs2Data;

    // EX stage
    Types::ExCtrl   exCtrl;
    Types::Data     exImm;
    Types::Data     exDataA;
    Types::Data     exDataB;
    Types::InstAddr exPc;
    Types::Data     exResult;
    logic           wbEnable;

    ApbInstPort #(
        .RESET_PC (RESET_PC))
    apbPort (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_legal   (legal),
        .i_busy    (exCtrl.valid),
        .i_regData (regData),
        .o_issue   (issue),
        .o_inst    (inst),
        .o_pc      (pc),
        .o_regIdx  (regIdx));

    InstDecoder decoder (
        .i_inst  (inst),
        .o_ctrl  (decCtrl),
        .o_imm   (idImm),
        .o_rs1   (rs1),
        .o_rs2   (rs2),
        .o_legal (legal));

    RegisterFile regFile (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_rs1   (rs1),
        .i_rs2   (rs2),
        .i_rs3   (regIdx),
        .i_we    (wbEnable),
        .i_rd    (exCtrl.rd),
        .i_wdata (exResult),
        .o_data1 (rs1Data),
        .o_data2 (rs2Data),
        .o_data3 (regData));

    // ----------------------------------------------------------------------
    // ID/EX pipeline register
    // ----------------------------------------------------------------------

    always_comb begin
        idCtrl       = decCtrl;
        idCtrl.valid = issue;            // Slot filled only on issue
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            exCtrl <= '0;
        end else begin
            exCtrl <= idCtrl;            // Valid drops after one cycle
        end
    end

    // Operands captured with the issue
    always_ff @(posedge i_clock) begin
        if (issue) begin
            exImm   <= idImm;
            exDataA <= rs1Data;
            exDataB <= rs2Data;
            exPc    <= pc;
        end
    end

    StageEX #(
        .DATA_WIDTH (DATA_WIDTH))
    stageEx (
        .i_ctrl    (exCtrl),
        .i_instImm (exImm),
        .i_dataA   (exDataA),
        .i_dataB   (exDataB),
        .i_pc      (exPc),
        .o_result  (exResult));

    // Writeback at the end of the EX cycle
    assign wbEnable = exCtrl.valid && exCtrl.we;

endmodule

//--- hdl/InstDecoder.sv
`timescale 1ns/1ns

module InstDecoder (
    input  Types::Inst     i_inst,
    output Types::ExCtrl   o_ctrl,
    output Types::Data     o_imm,       // I or U immediate
    output Types::RegIndex o_rs1,
    output Types::RegIndex o_rs2,
    output logic           o_legal);    // Supported encoding

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    // funct3 to ALU op where alt picks SUB or SRA
    function automatic Types::AluOp aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? Types::ALU_SUB : Types::ALU_ADD;
            3'b001:  return Types::ALU_SLL;
            3'b010:  return Types::ALU_SLT;
            3'b011:  return Types::ALU_SLTU;
            3'b100:  return Types::ALU_XOR;
            3'b101:  return alt ? Types::ALU_SRA : Types::ALU_SRL;
            3'b110:  return Types::ALU_OR;
            default: return Types::ALU_AND;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Field decode
    // ----------------------------------------------------------------------

    always_comb begin
        o_ctrl.aluOp = Types::ALU_ADD;
        o_ctrl.aSel  = Types::RS1;
        o_ctrl.bSel  = Types::RS2;
        o_ctrl.rd    = i_inst[11:7];
        o_ctrl.valid = 1'b0;                                 // Set from issue at top
        o_imm        = {{20{i_inst[31]}}, i_inst[31:20]};    // I-type by default
        o_legal      = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_ctrl.aluOp = aluFromFunct3(funct3, funct7[5]);
                // Alternate funct7 only on SUB and SRA
                o_legal = (funct7 == 7'b0000000)
                    || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                o_ctrl.bSel  = Types::IMM;
                o_ctrl.aluOp = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
                case (funct3)
                    3'b001:  o_legal = funct7 == 7'b0000000;    // SLLI
                    3'b101:  o_legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                    default: o_legal = 1'b1;                     // Any immediate
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                o_ctrl.aSel = (opcode == OPC_LUI) ? Types::ZERO : Types::PC;
                o_ctrl.bSel = Types::IMM;
                o_imm       = {i_inst[31:12], 12'b0};           // U-type
                o_legal     = 1'b1;
            end
            default: o_legal = 1'b0;
        endcase
        o_ctrl.we = o_legal;                                 // Every legal op writes rd
    end

endmodule

//--- hdl/RegisterFile.sv
`timescale 1ns/1ns

module RegisterFile (
    input  logic           i_clock,
    input  logic           i_rst,
    input  Types::RegIndex i_rs1,      // Pipeline read port 1
    input  Types::RegIndex i_rs2,      // Pipeline read port 2
    input  Types::RegIndex i_rs3,      // APB readback
    input  logic           i_we,
    input  Types::RegIndex i_rd,
    input  Types::Data     i_wdata,
    output Types::Data     o_data1,
    output Types::Data     o_data2,
    output Types::Data     o_data3);

    Types::Data regs [32];

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != 5'd0) begin    // x0 stays zero
            regs[i_rd] <= i_wdata;
        end
    end

    // Asynchronous reads
    assign o_data1 = regs[i_rs1];
    assign o_data2 = regs[i_rs2];
    assign o_data3 = regs[i_rs3];

endmodule

//--- hdl/StageEX.sv
`timescale 1ns/1ns

module StageEX #(
    parameter int DATA_WIDTH = 32)
(
    input  Types::ExCtrl   i_ctrl,       // Control from the ID/EX register
    input  Types::Data     i_instImm,    // Immediate of the instruction
    input  Types::Data     i_dataA,      // rs1 data
    input  Types::Data     i_dataB,      // rs2 data
    input  Types::InstAddr i_pc,         // Address of the instruction
    output Types::Data     o_result);    // Value for writeback

    // ----------------------------------------------------------------------
    // Operand A for the ALU
    // ----------------------------------------------------------------------

    Types::Data operandA;

    always_comb begin
        case (i_ctrl.aSel)
            Types::RS1:  operandA = i_dataA;
            Types::PC:   operandA = Types::Data'(i_pc);    // AUIPC base
            Types::ZERO: operandA = {DATA_WIDTH{1'b0}};    // LUI passes imm
            default:     operandA = i_dataA;
        endcase
    end

    // ----------------------------------------------------------------------
    // Operand B for the ALU
    // ----------------------------------------------------------------------

    Types::Data operandB;

    assign operandB = (i_ctrl.bSel == Types::IMM) ? i_instImm : i_dataB;

    // ALU proper
    ALU #(
        .DATA_WIDTH (DATA_WIDTH))
    alu (
        .i_op       (i_ctrl.aluOp),
        .i_operandA (operandA),
        .i_operandB (operandB),
        .o_result   (o_result));

endmodule

//--- hdl/Types.sv
package Types;

    // ----------------------------------------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------------------------------------

    typedef logic [31:0] Data;        // Machine word
    typedef logic [31:0] InstAddr;    // Instruction address
    typedef logic [31:0] Inst;        // Raw instruction word
    typedef logic [4:0]  RegIndex;    // x0 up to x31
    typedef logic [7:0]  ApbAddr;     // APB byte address

    // ALU operations of RV32I
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,                      // Signed compare
        ALU_SLTU,                     // Unsigned compare
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } AluOp;

    typedef enum logic [1:0] {
        RS1,                          // Register source 1
        PC,                           // AUIPC
        ZERO                          // LUI
    } OperandASel;

    typedef enum logic {
        RS2,                          // Register source 2
        IMM                           // I or U immediate
    } OperandBSel;

    // Control travelling from ID through EX to writeback
    typedef struct packed {
        AluOp       aluOp;
        OperandASel aSel;
        OperandBSel bSel;
        RegIndex    rd;               // Destination register
        logic       we;               // Writes rd
        logic       valid;            // Slot holds an issued instruction
    } ExCtrl;

    // APB register map
    localparam ApbAddr INST_ADDR = 8'h00;   // Write issues an instruction
    localparam ApbAddr PC_ADDR   = 8'h04;
    localparam ApbAddr REG_BASE  = 8'h80;   // x0 at 0x80 up to x31 at 0xFC

endpackage

//--- run.sh
#!/bin/sh
# Build and run the ExecCore testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ExecCore_tb \
    -f ExecCore.f -o simExecCore

./obj_dir/simExecCore | tee sim.log

# Result comes from the log
grep -q "All checks passed" sim.log
